//--- mesi_pkg.sv
`default_nettype none

package mesi_pkg;

  parameter int XLEN       = 32;
  parameter int LINE_WIDTH = 32;
  parameter int NUM_CPUS   = 4;

  typedef logic [XLEN-1:0]       addr_t;
  typedef logic [LINE_WIDTH-1:0] line_data_t;

  // bus and crossbar endpoint with cpus first and memory after them
  typedef logic [2:0] node_id_t;

  localparam node_id_t MEM_NODE = node_id_t'(NUM_CPUS);

  // stable states first, then the transients of a pending miss
  typedef enum logic [2:0] {
    I,
    S,
    E,
    M,
    IS,
    IE,
    IM,
    SM
  } mesi_state_t;

  typedef enum logic [2:0] {
    Bus_Idle,
    Bus_Rd,
    Bus_Rdx,
    Bus_Upg,
    Bus_Flush
  } bus_tx_t;

  // state change asked of the line store by a snoop hit
  typedef enum logic [1:0] {
    SNOOP_NONE,
    SNOOP_TO_S,
    SNOOP_TO_I
  } snoop_act_t;

endpackage

`default_nettype wire

//--- line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store #(
  parameter int NUM_SETS = 4
) (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    cpu_req,
  input  wire logic                    cpu_we,
  input  mesi_pkg::addr_t              cpu_addr,
  input  mesi_pkg::line_data_t         cpu_wdata,
  input  wire logic                    issue_valid,
  input  mesi_pkg::bus_tx_t            issue_tx,
  input  wire logic                    bus_shared,
  input  wire logic                    fill_valid,
  input  mesi_pkg::line_data_t         fill_data,
  input  mesi_pkg::snoop_act_t         snoop_act,
  input  wire logic [$clog2(NUM_SETS)-1:0] snoop_index,
  output logic                         cpu_ready,
  output logic                         cpu_resp,
  output mesi_pkg::line_data_t         cpu_rdata,
  output mesi_pkg::mesi_state_t        cpu_state,
  output mesi_pkg::mesi_state_t        snoop_state,
  output mesi_pkg::line_data_t         snoop_data,
  output logic                         arbiter_busy
);

  localparam int IDX_W = $clog2(NUM_SETS);

  mesi_pkg::mesi_state_t state_q [NUM_SETS];
  mesi_pkg::line_data_t  data_q  [NUM_SETS];

  logic [IDX_W-1:0]      cpu_idx;
  logic                  cpu_upd;
  mesi_pkg::mesi_state_t cpu_next_state;
  mesi_pkg::line_data_t  cpu_next_data;
  logic                  snoop_on_cpu;

  assign cpu_idx      = cpu_addr[IDX_W-1:0];
  assign cpu_state    = state_q[cpu_idx];
  assign snoop_state  = state_q[snoop_index];
  assign snoop_data   = data_q[snoop_index];
  assign snoop_on_cpu = (snoop_act != mesi_pkg::SNOOP_NONE) && (snoop_index == cpu_idx);

  always_comb begin
    arbiter_busy = 1'b0;
    for (int i = 0; i < NUM_SETS; i++) begin
      if (state_q[i] inside {mesi_pkg::IS, mesi_pkg::IE, mesi_pkg::IM, mesi_pkg::SM}) begin
        arbiter_busy = 1'b1;
      end
    end
  end

  // hits, issue moves and transient resolution on the local side
  always_comb begin
    cpu_resp       = 1'b0;
    cpu_rdata      = '0;
    cpu_upd        = 1'b0;
    cpu_next_state = cpu_state;
    cpu_next_data  = data_q[cpu_idx];
    case (cpu_state)
      mesi_pkg::M, mesi_pkg::E: begin
        if (cpu_req) begin
          cpu_resp = 1'b1;
          if (cpu_we) begin
            // silent upgrade from E
            cpu_upd        = 1'b1;
            cpu_next_state = mesi_pkg::M;
            cpu_next_data  = cpu_wdata;
          end else begin
            cpu_rdata = data_q[cpu_idx];
          end
        end
      end
      mesi_pkg::S: begin
        if (cpu_req && !cpu_we) begin
          cpu_resp  = 1'b1;
          cpu_rdata = data_q[cpu_idx];
        end else if (issue_valid) begin
          cpu_upd        = 1'b1;
          cpu_next_state = mesi_pkg::SM;
        end
      end
      mesi_pkg::I: begin
        if (issue_valid) begin
          cpu_upd = 1'b1;
          if (issue_tx == mesi_pkg::Bus_Rdx) begin
            cpu_next_state = mesi_pkg::IM;
          end else begin
            cpu_next_state = bus_shared ? mesi_pkg::IS : mesi_pkg::IE;
          end
        end
      end
      mesi_pkg::IS, mesi_pkg::IE: begin
        if (fill_valid) begin
          cpu_resp       = 1'b1;
          cpu_rdata      = fill_data;
          cpu_upd        = 1'b1;
          cpu_next_state = (cpu_state == mesi_pkg::IS) ? mesi_pkg::S : mesi_pkg::E;
          cpu_next_data  = fill_data;
        end
      end
      default: begin
        // IM and SM finish the cycle after the grant
        cpu_resp       = 1'b1;
        cpu_upd        = 1'b1;
        cpu_next_state = mesi_pkg::M;
        cpu_next_data  = cpu_wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_SETS; i++) begin
        state_q[i] <= mesi_pkg::I;
        data_q[i]  <= '0;
      end
      cpu_ready <= 1'b1;
    end else begin
      if (cpu_upd) begin
        state_q[cpu_idx] <= cpu_next_state;
        data_q[cpu_idx]  <= cpu_next_data;
      end
      // snoop comes last and wins a shared set
      case (snoop_act)
        mesi_pkg::SNOOP_TO_S: state_q[snoop_index] <= mesi_pkg::S;
        mesi_pkg::SNOOP_TO_I: state_q[snoop_index] <= mesi_pkg::I;
        default: ;
      endcase
      if (cpu_resp) begin
        cpu_ready <= 1'b1;
      end else if (cpu_req) begin
        cpu_ready <= 1'b0;
      end
    end
  end

  for (genvar g = 0; g < NUM_SETS; g++) begin : g_set_chk
    a_issue_from_i: assert property (@(posedge clk) disable iff (rst)
      issue_valid && cpu_idx == IDX_W'(g) && !snoop_on_cpu && state_q[g] == mesi_pkg::I
      |=> state_q[g] inside {mesi_pkg::IS, mesi_pkg::IE, mesi_pkg::IM})
      else $error("set %0d: issue from I did not enter IS/IE/IM", g);

    a_issue_from_s: assert property (@(posedge clk) disable iff (rst)
      issue_valid && cpu_idx == IDX_W'(g) && !snoop_on_cpu && state_q[g] == mesi_pkg::S
      |=> state_q[g] == mesi_pkg::SM)
      else $error("set %0d: upgrade from S did not enter SM", g);

    // relies on the CPU holding its address until the response
    a_im_sm_resolve: assert property (@(posedge clk) disable iff (rst)
      state_q[g] inside {mesi_pkg::IM, mesi_pkg::SM} |=> state_q[g] == mesi_pkg::M)
      else $error("set %0d: IM/SM did not resolve to M", g);

    a_write_data: assert property (@(posedge clk) disable iff (rst)
      cpu_req && cpu_we && cpu_resp && cpu_idx == IDX_W'(g)
      |=> data_q[g] == $past(cpu_wdata))
      else $error("set %0d: written data not stored", g);
  end

endmodule

`default_nettype wire

//--- miss_requester.sv
`timescale 1ns/1ps
`default_nettype none

module miss_requester #(
  parameter int NUM_SETS = 4
) (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             cpu_req,
  input  wire logic             cpu_we,
  input  mesi_pkg::addr_t       cpu_addr,
  input  mesi_pkg::mesi_state_t cpu_state,
  input  wire logic             arbiter_gnt,
  output logic                  arbiter_req,
  output logic                  issue_valid,
  output mesi_pkg::bus_tx_t     issue_tx,
  output mesi_pkg::bus_tx_t     miss_tx,
  output mesi_pkg::addr_t       miss_addr
);

  localparam int IDX_W = $clog2(NUM_SETS);

  mesi_pkg::bus_tx_t need_tx;

  // transaction needed by the current access (idle on a hit or a transient)
  always_comb begin
    need_tx = mesi_pkg::Bus_Idle;
    if (cpu_req) begin
      if (cpu_state == mesi_pkg::I) begin
        need_tx = cpu_we ? mesi_pkg::Bus_Rdx : mesi_pkg::Bus_Rd;
      end else if (cpu_state == mesi_pkg::S && cpu_we) begin
        need_tx = mesi_pkg::Bus_Upg;
      end
    end
  end

  assign arbiter_req = (need_tx != mesi_pkg::Bus_Idle);
  assign issue_valid = arbiter_req && arbiter_gnt;
  assign issue_tx    = issue_valid ? need_tx : mesi_pkg::Bus_Idle;

  // bus only carries the miss in the grant cycle
  assign miss_tx   = issue_tx;
  assign miss_addr = issue_valid ? cpu_addr : '0;

  // a waiting miss keeps its set and its request until granted
  a_wait_holds_set: assert property (@(posedge clk) disable iff (rst)
    arbiter_req && !arbiter_gnt
    |=> arbiter_req && cpu_addr[IDX_W-1:0] == $past(cpu_addr[IDX_W-1:0]))
    else $error("pending miss dropped or changed set before grant");

endmodule

`default_nettype wire

//--- snoop_responder.sv
`timescale 1ns/1ps
`default_nettype none

module snoop_responder #(
  parameter int                 NUM_SETS = 4,
  parameter mesi_pkg::node_id_t CPU_ID   = 3'd0
) (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     bus_msg_valid,
  input  mesi_pkg::bus_tx_t             bus_msg_tx,
  input  mesi_pkg::addr_t               bus_msg_addr,
  input  mesi_pkg::node_id_t            bus_msg_source,
  input  mesi_pkg::mesi_state_t         snoop_state,
  input  mesi_pkg::line_data_t          snoop_data,
  output logic [$clog2(NUM_SETS)-1:0]   snoop_index,
  output mesi_pkg::snoop_act_t          snoop_act,
  output logic                          flush_now,
  output logic                          mem_wb_valid,
  output mesi_pkg::addr_t               mem_wb_addr,
  output mesi_pkg::line_data_t          mem_wb_data,
  output logic                          c2c_valid,
  output mesi_pkg::node_id_t            c2c_dest,
  output mesi_pkg::addr_t               c2c_addr,
  output mesi_pkg::line_data_t          c2c_data
);

  localparam int IDX_W = $clog2(NUM_SETS);

  logic remote;
  logic line_valid;
  logic send_c2c;

  assign snoop_index = bus_msg_addr[IDX_W-1:0];
  // own messages come back on the bus too
  assign remote      = bus_msg_valid && (bus_msg_source != CPU_ID);
  assign line_valid  = snoop_state inside {mesi_pkg::M, mesi_pkg::E, mesi_pkg::S};

  always_comb begin
    snoop_act = mesi_pkg::SNOOP_NONE;
    flush_now = 1'b0;
    send_c2c  = 1'b0;
    if (remote) begin
      case (bus_msg_tx)
        mesi_pkg::Bus_Rd: begin
          if (line_valid) begin
            snoop_act = mesi_pkg::SNOOP_TO_S;
            flush_now = 1'b1;
            send_c2c  = 1'b1;
          end
        end
        mesi_pkg::Bus_Rdx: begin
          if (line_valid) begin
            snoop_act = mesi_pkg::SNOOP_TO_I;
            flush_now = 1'b1;
          end
        end
        mesi_pkg::Bus_Upg: begin
          // a line in S is clean and needs no write back
          if (snoop_state == mesi_pkg::S) begin
            snoop_act = mesi_pkg::SNOOP_TO_I;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb_valid <= 1'b0;
      c2c_valid    <= 1'b0;
    end else begin
      mem_wb_valid <= flush_now;
      c2c_valid    <= send_c2c;
    end
  end

  // payload shared by the memory flush and the c2c copy
  always_ff @(posedge clk) begin
    if (flush_now) begin
      mem_wb_addr <= bus_msg_addr;
      mem_wb_data <= snoop_data;
      c2c_dest    <= bus_msg_source;
    end
  end

  assign c2c_addr = mem_wb_addr;
  assign c2c_data = mem_wb_data;

  // another cache upgrading means our copy cannot be exclusive
  a_upg_not_exclusive: assert property (@(posedge clk) disable iff (rst)
    remote && bus_msg_tx == mesi_pkg::Bus_Upg
    |-> !(snoop_state inside {mesi_pkg::M, mesi_pkg::E}))
    else $error("remote upgrade seen while line held in M or E");

endmodule

`default_nettype wire

//--- mesi_cache.sv
`timescale 1ns/1ps
`default_nettype none

module mesi_cache #(
  parameter int                 NUM_SETS = 4,
  parameter mesi_pkg::node_id_t CPU_ID   = 3'd0
) (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 cpu_req,
  input  wire logic                 cpu_we,
  input  mesi_pkg::addr_t           cpu_addr,
  input  mesi_pkg::line_data_t      cpu_wdata,
  input  wire logic                 arbiter_gnt,
  input  wire logic                 bus_shared,
  input  wire logic                 fill_valid,
  input  mesi_pkg::line_data_t      fill_data,
  input  wire logic                 bus_msg_valid,
  input  mesi_pkg::bus_tx_t         bus_msg_tx,
  input  mesi_pkg::addr_t           bus_msg_addr,
  input  mesi_pkg::node_id_t        bus_msg_source,
  output logic                      cpu_ready,
  output logic                      cpu_resp,
  output mesi_pkg::line_data_t      cpu_rdata,
  output logic                      arbiter_req,
  output logic                      arbiter_busy,
  output mesi_pkg::bus_tx_t         bus_tx,
  output mesi_pkg::addr_t           bus_addr,
  output logic                      mem_wb_valid,
  output mesi_pkg::addr_t           mem_wb_addr,
  output mesi_pkg::line_data_t      mem_wb_data,
  output logic                      c2c_valid,
  output mesi_pkg::node_id_t        c2c_dest,
  output mesi_pkg::addr_t           c2c_addr,
  output mesi_pkg::line_data_t      c2c_data
);

  localparam int IDX_W = $clog2(NUM_SETS);

  mesi_pkg::mesi_state_t cpu_state;
  mesi_pkg::mesi_state_t snoop_state;
  mesi_pkg::line_data_t  snoop_data;
  logic                  issue_valid;
  mesi_pkg::bus_tx_t     issue_tx;
  mesi_pkg::bus_tx_t     miss_tx;
  mesi_pkg::snoop_act_t  snoop_act;
  logic [IDX_W-1:0]      snoop_index;
  logic                  flush_now;

  line_store #(
    .NUM_SETS(NUM_SETS)
  ) u_line_store (
    .clk(clk), .rst(rst),
    .cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
    .issue_valid(issue_valid), .issue_tx(issue_tx), .bus_shared(bus_shared),
    .fill_valid(fill_valid), .fill_data(fill_data),
    .snoop_act(snoop_act), .snoop_index(snoop_index),
    .cpu_ready(cpu_ready), .cpu_resp(cpu_resp), .cpu_rdata(cpu_rdata),
    .cpu_state(cpu_state), .snoop_state(snoop_state), .snoop_data(snoop_data),
    .arbiter_busy(arbiter_busy)
  );

  miss_requester #(
    .NUM_SETS(NUM_SETS)
  ) u_miss_requester (
    .clk(clk), .rst(rst),
    .cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_state(cpu_state),
    .arbiter_gnt(arbiter_gnt), .arbiter_req(arbiter_req),
    .issue_valid(issue_valid), .issue_tx(issue_tx),
    .miss_tx(miss_tx), .miss_addr(bus_addr)
  );

  snoop_responder #(
    .NUM_SETS(NUM_SETS),
    .CPU_ID(CPU_ID)
  ) u_snoop_responder (
    .clk(clk), .rst(rst),
    .bus_msg_valid(bus_msg_valid), .bus_msg_tx(bus_msg_tx),
    .bus_msg_addr(bus_msg_addr), .bus_msg_source(bus_msg_source),
    .snoop_state(snoop_state), .snoop_data(snoop_data),
    .snoop_index(snoop_index), .snoop_act(snoop_act), .flush_now(flush_now),
    .mem_wb_valid(mem_wb_valid), .mem_wb_addr(mem_wb_addr), .mem_wb_data(mem_wb_data),
    .c2c_valid(c2c_valid), .c2c_dest(c2c_dest), .c2c_addr(c2c_addr), .c2c_data(c2c_data)
  );

  // flush takes the bus over a granted miss
  assign bus_tx = flush_now ? mesi_pkg::Bus_Flush : miss_tx;

endmodule

`default_nettype wire

//--- tb_mesi_tasks.svh
`ifndef TB_MESI_TASKS_SVH
`define TB_MESI_TASKS_SVH

task automatic expect_val(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
  checks++;
  assert (got === exp) else begin
    errors++;
    $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
  end
endtask

// present one cpu access, then look at the combinational response
task automatic start_access(input logic we, input mesi_pkg::addr_t addr,
                            input mesi_pkg::line_data_t wdata);
  @(posedge clk);
  cpu_req   <= 1'b1;
  cpu_we    <= we;
  cpu_addr  <= addr;
  cpu_wdata <= wdata;
  @(negedge clk);
endtask

task automatic end_access();
  @(posedge clk);
  cpu_req    <= 1'b0;
  fill_valid <= 1'b0;
  @(negedge clk);
  expect_val("cpu_ready", cpu_ready, 1);
  expect_val("arbiter_busy", arbiter_busy, 0);
endtask

task automatic hit_access(input logic we, input mesi_pkg::addr_t addr,
                          input mesi_pkg::line_data_t data);
  start_access(we, addr, data);
  expect_val("arbiter_req", arbiter_req, 0);
  expect_val("cpu_resp", cpu_resp, 1);
  if (we) begin
    line_model[addr % NUM_SETS] = data;
  end else begin
    expect_val("cpu_rdata", cpu_rdata, data);
  end
  end_access();
endtask

// arbiter model granting a pending request after 0 to 3 idle cycles
task automatic grant_bus(input mesi_pkg::bus_tx_t tx, input mesi_pkg::addr_t addr,
                         input logic shared);
  int unsigned delay;
  delay = $urandom_range(3, 0);
  while (!arbiter_req) @(negedge clk);
  repeat (delay) @(posedge clk);
  @(posedge clk);
  arbiter_gnt <= 1'b1;
  bus_shared  <= shared;
  @(negedge clk);
  expect_val("cpu_ready", cpu_ready, 0);
  expect_val("bus_tx", bus_tx, tx);
  expect_val("bus_addr", bus_addr, addr);
  @(posedge clk);
  arbiter_gnt <= 1'b0;
  bus_shared  <= 1'b0;
endtask

// fill comes from the memory model a few cycles after the grant
task automatic read_miss(input mesi_pkg::addr_t addr, input logic shared);
  int unsigned          delay;
  mesi_pkg::line_data_t data;
  data  = mem_model[addr % NUM_SETS];
  delay = $urandom_range(3, 0);
  start_access(1'b0, addr, '0);
  expect_val("cpu_resp", cpu_resp, 0);
  expect_val("arbiter_req", arbiter_req, 1);
  grant_bus(mesi_pkg::Bus_Rd, addr, shared);
  @(negedge clk);
  expect_val("arbiter_busy", arbiter_busy, 1);
  repeat (delay) @(posedge clk);
  @(posedge clk);
  fill_valid <= 1'b1;
  fill_data  <= data;
  @(negedge clk);
  expect_val("cpu_resp", cpu_resp, 1);
  expect_val("cpu_rdata", cpu_rdata, data);
  line_model[addr % NUM_SETS] = data;
  end_access();
endtask

task automatic write_bus(input mesi_pkg::addr_t addr, input mesi_pkg::line_data_t data,
                         input mesi_pkg::bus_tx_t tx);
  start_access(1'b1, addr, data);
  expect_val("arbiter_req", arbiter_req, 1);
  grant_bus(tx, addr, 1'b0);
  @(negedge clk);
  // IM and SM answer one cycle after the grant
  expect_val("cpu_resp", cpu_resp, 1);
  line_model[addr % NUM_SETS] = data;
  end_access();
endtask

// remote message, then the registered flush and c2c copy
task automatic snoop_msg(input mesi_pkg::bus_tx_t tx, input mesi_pkg::addr_t addr,
                         input mesi_pkg::node_id_t src, input logic flush,
                         input logic c2c, input mesi_pkg::line_data_t data);
  @(posedge clk);
  bus_msg_valid  <= 1'b1;
  bus_msg_tx     <= tx;
  bus_msg_addr   <= addr;
  bus_msg_source <= src;
  @(negedge clk);
  expect_val("bus_tx", bus_tx, flush ? mesi_pkg::Bus_Flush : mesi_pkg::Bus_Idle);
  @(posedge clk);
  bus_msg_valid <= 1'b0;
  @(negedge clk);
  expect_val("mem_wb_valid", mem_wb_valid, flush);
  expect_val("c2c_valid", c2c_valid, c2c);
  if (flush) begin
    expect_val("mem_wb_addr", mem_wb_addr, addr);
    expect_val("mem_wb_data", mem_wb_data, data);
    mem_model[addr % NUM_SETS] = data;
  end
  if (c2c) begin
    expect_val("c2c_dest", c2c_dest, src);
    expect_val("c2c_addr", c2c_addr, addr);
    expect_val("c2c_data", c2c_data, data);
  end
endtask

`endif

//--- tb_mesi_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mesi_cache;

  localparam int                 NUM_SETS   = 4;
  localparam mesi_pkg::node_id_t CPU_ID     = 3'd1;
  // worst case of the sequence is near 100 cycles
  localparam int                 MAX_CYCLES = 400;

  logic                 clk;
  logic                 rst;
  logic                 cpu_req;
  logic                 cpu_we;
  mesi_pkg::addr_t      cpu_addr;
  mesi_pkg::line_data_t cpu_wdata;
  logic                 arbiter_gnt;
  logic                 bus_shared;
  logic                 fill_valid;
  mesi_pkg::line_data_t fill_data;
  logic                 bus_msg_valid;
  mesi_pkg::bus_tx_t    bus_msg_tx;
  mesi_pkg::addr_t      bus_msg_addr;
  mesi_pkg::node_id_t   bus_msg_source;
  logic                 cpu_ready;
  logic                 cpu_resp;
  mesi_pkg::line_data_t cpu_rdata;
  logic                 arbiter_req;
  logic                 arbiter_busy;
  mesi_pkg::bus_tx_t    bus_tx;
  mesi_pkg::addr_t      bus_addr;
  logic                 mem_wb_valid;
  mesi_pkg::addr_t      mem_wb_addr;
  mesi_pkg::line_data_t mem_wb_data;
  logic                 c2c_valid;
  mesi_pkg::node_id_t   c2c_dest;
  mesi_pkg::addr_t      c2c_addr;
  mesi_pkg::line_data_t c2c_data;

  int                   errors;
  int                   checks;
  int                   cycles;
  mesi_pkg::line_data_t mem_model  [NUM_SETS];
  mesi_pkg::line_data_t line_model [NUM_SETS];

  mesi_cache #(
    .NUM_SETS(NUM_SETS),
    .CPU_ID(CPU_ID)
  ) uut (.*);

  `include "tb_mesi_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout: run not finished after %0d cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic test_reset();
    @(negedge clk);
    expect_val("cpu_ready", cpu_ready, 1);
    expect_val("arbiter_req", arbiter_req, 0);
    expect_val("bus_tx", bus_tx, mesi_pkg::Bus_Idle);
    expect_val("mem_wb_valid", mem_wb_valid, 0);
    expect_val("c2c_valid", c2c_valid, 0);
  endtask

  // E goes to M on a write without the bus
  task automatic test_read_exclusive();
    read_miss(32'h1000, 1'b0);
    hit_access(1'b0, 32'h1000, line_model[0]);
    hit_access(1'b1, 32'h1000, $urandom);
  endtask

  task automatic test_shared_upgrade();
    read_miss(32'h1001, 1'b1);
    write_bus(32'h1001, $urandom, mesi_pkg::Bus_Upg);
    hit_access(1'b0, 32'h1001, line_model[1]);
  endtask

  task automatic test_write_miss();
    write_bus(32'h1002, $urandom, mesi_pkg::Bus_Rdx);
    hit_access(1'b0, 32'h1002, line_model[2]);
  endtask

  task automatic test_remote_snoops();
    snoop_msg(mesi_pkg::Bus_Rd, 32'h1000, 3'd2, 1'b1, 1'b1, line_model[0]);
    write_bus(32'h1000, $urandom, mesi_pkg::Bus_Upg);
    snoop_msg(mesi_pkg::Bus_Rdx, 32'h1002, 3'd3, 1'b1, 1'b0, line_model[2]);
    read_miss(32'h1002, 1'b0);
    read_miss(32'h1003, 1'b1);
    snoop_msg(mesi_pkg::Bus_Upg, 32'h1003, 3'd0, 1'b0, 1'b0, '0);
    read_miss(32'h1003, 1'b0);
  endtask

  task automatic test_own_snoop();
    snoop_msg(mesi_pkg::Bus_Rdx, 32'h1001, CPU_ID, 1'b0, 1'b0, '0);
    hit_access(1'b0, 32'h1001, line_model[1]);
  endtask

  initial begin
    // first call seeds the generator for the whole run
    mem_model[0] = $urandom(37924);
    for (int i = 1; i < NUM_SETS; i++) begin
      mem_model[i] = $urandom;
    end
    rst            = 1'b1;
    cpu_req        = 1'b0;
    cpu_we         = 1'b0;
    cpu_addr       = '0;
    cpu_wdata      = '0;
    arbiter_gnt    = 1'b0;
    bus_shared     = 1'b0;
    fill_valid     = 1'b0;
    fill_data      = '0;
    bus_msg_valid  = 1'b0;
    bus_msg_tx     = mesi_pkg::Bus_Idle;
    bus_msg_addr   = '0;
    bus_msg_source = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_read_exclusive();
    test_shared_upgrade();
    test_write_miss();
    test_remote_snoops();
    test_own_snoop();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
mesi_pkg.sv
line_store.sv
miss_requester.sv
snoop_responder.sv
mesi_cache.sv
tb_mesi_cache.sv
